/* src/i3c_stby_consts.svh */
`ifndef I3C_STBY_CONSTS_SVH
`define I3C_STBY_CONSTS_SVH

// Bus widths
`define CSR_ADDR_W 12
`define CSR_DATA_W 32
`define I3C_ADDR_W 7
`define RSTACT_W   8

// Register offsets
`define ADDR_DEVICE_ADDR      12'h000
`define ADDR_VIRT_DEVICE_ADDR 12'h004
`define ADDR_RSTACT_PARAMS    12'h008
`define ADDR_CONTROL          12'h00C

// Control register fields
`define CTRL_XACT_EN_BIT 0

`endif

/* src/i3c_stby_pkg.sv */
`default_nettype none

`include "i3c_stby_consts.svh"

package i3c_stby_pkg;

    // Address register layout, reserved bits read as zero
    typedef struct packed {
        logic                   dyn_valid;    // [31]
        logic [7:0]             rsvd_hi;      // [30:23]
        logic [`I3C_ADDR_W-1:0] dyn_addr;     // [22:16]
        logic                   static_valid; // [15]
        logic [7:0]             rsvd_lo;      // [14:7]
        logic [`I3C_ADDR_W-1:0] static_addr;  // [6:0]
    } dev_addr_t;

    // One CSR word, seen raw or as address fields
    typedef union packed {
        logic [`CSR_DATA_W-1:0] raw;
        dev_addr_t              addr;
    } csr_word_u;

endpackage : i3c_stby_pkg

`default_nettype wire

/* src/ccc_addr_if.sv */
`timescale 1ns/1ns
`default_nettype none

`include "i3c_stby_consts.svh"

// Hardware write requests from the CCC decode into the register file
interface ccc_addr_if;

    logic                   dev_we;         // Device reg dynamic fields
    logic                   virt_we;        // Virtual reg dynamic fields
    logic [`I3C_ADDR_W-1:0] dyn_addr_next;
    logic                   dyn_valid_next;
    logic                   rstact_we;
    logic [`RSTACT_W-1:0]   rstact_next;

    modport src (
        output dev_we,
        output virt_we,
        output dyn_addr_next,
        output dyn_valid_next,
        output rstact_we,
        output rstact_next
    );

    modport dst (
        input dev_we,
        input virt_we,
        input dyn_addr_next,
        input dyn_valid_next,
        input rstact_we,
        input rstact_next
    );

endinterface : ccc_addr_if

`default_nettype wire

/* src/ccc_addr_update.sv */
`timescale 1ns/1ns
`default_nettype none

`include "i3c_stby_consts.svh"

module ccc_addr_update (
    // SETDASA / RSTDAA
    input wire logic [`I3C_ADDR_W-1:0] set_dasa_i,
    input wire logic                   set_dasa_valid_i,
    input wire logic                   set_dasa_virtual_i,
    input wire logic                   rstdaa_i,

    // SETNEWDA
    input wire logic [`I3C_ADDR_W-1:0] newda_i,
    input wire logic                   set_newda_i,
    input wire logic                   set_newda_virtual_i,

    // RSTACT
    input wire logic [`RSTACT_W-1:0]   rst_action_i,
    input wire logic                   rst_action_valid_i,

    ccc_addr_if.src                    upd_o
);

    logic dasa_grp; // SETDASA or RSTDAA present
    logic newda_grp;

    assign dasa_grp  = set_dasa_valid_i | rstdaa_i;
    assign newda_grp = set_newda_i | set_newda_virtual_i;

    always_comb begin : addr_update
        upd_o.dev_we         = 1'b0;
        upd_o.virt_we        = 1'b0;
        upd_o.dyn_addr_next  = '0;
        upd_o.dyn_valid_next = 1'b0;

        if (dasa_grp) begin
            // Same steering bit for both CCCs of this group
            upd_o.dev_we  = ~set_dasa_virtual_i;
            upd_o.virt_we = set_dasa_virtual_i;
            if (rstdaa_i) begin
                upd_o.dyn_addr_next  = '0; // Address cleared, valid dropped
                upd_o.dyn_valid_next = 1'b0;
            end else begin
                upd_o.dyn_addr_next  = set_dasa_i;
                upd_o.dyn_valid_next = 1'b1;
            end
        end else if (newda_grp) begin
            upd_o.dev_we         = set_newda_i;
            upd_o.virt_we        = set_newda_virtual_i;
            upd_o.dyn_addr_next  = newda_i;
            upd_o.dyn_valid_next = 1'b1;
        end
    end

    // Reset action passes straight through
    assign upd_o.rstact_we   = rst_action_valid_i;
    assign upd_o.rstact_next = rst_action_i;

endmodule : ccc_addr_update

`default_nettype wire

/* src/stby_csr_regs.sv */
`timescale 1ns/1ns
`default_nettype none

`include "i3c_stby_consts.svh"

module stby_csr_regs
    import i3c_stby_pkg::*;
(
    input  wire logic                   clk_i,
    input  wire logic                   arst_n_i,

    // CPU port
    input  wire logic                   cpu_req_i,
    input  wire logic                   cpu_req_is_wr_i,
    input  wire logic [`CSR_ADDR_W-1:0] cpu_addr_i,
    input  wire logic [`CSR_DATA_W-1:0] cpu_wr_data_i,
    output logic                        cpu_rd_ack_o,
    output logic                        cpu_rd_err_o,
    output logic [`CSR_DATA_W-1:0]      cpu_rd_data_o,
    output logic                        cpu_wr_ack_o,
    output logic                        cpu_wr_err_o,

    // Hardware updates
    ccc_addr_if.dst                     upd_i,

    // Register values
    output dev_addr_t                   dev_addr_o,
    output dev_addr_t                   virt_addr_o,
    output logic                        xact_en_o,
    output logic [`RSTACT_W-1:0]        rst_action_o
);

    csr_word_u            wr_word;
    csr_word_u            rd_word;
    dev_addr_t            dev_addr_q;
    dev_addr_t            dev_addr_d;
    dev_addr_t            virt_addr_q;
    dev_addr_t            virt_addr_d;
    logic [`RSTACT_W-1:0] rstact_q;
    logic                 xact_en_q;
    logic                 xact_en_d;
    logic                 hit_dev;
    logic                 hit_virt;
    logic                 hit_rstact;
    logic                 hit_ctrl;
    logic                 hit_any;
    logic                 wr_req;
    logic                 rd_req;

    // Software write first, hardware update on top of the dynamic fields
    function automatic dev_addr_t merge_addr(
        input dev_addr_t              cur,
        input logic                   sw_we,
        input dev_addr_t              sw_val,
        input logic                   hw_we,
        input logic [`I3C_ADDR_W-1:0] hw_addr,
        input logic                   hw_valid
    );
        dev_addr_t nxt;
        nxt = cur;
        if (sw_we) begin
            nxt.static_addr  = sw_val.static_addr;
            nxt.static_valid = sw_val.static_valid;
            nxt.dyn_addr     = sw_val.dyn_addr;
            nxt.dyn_valid    = sw_val.dyn_valid;
        end
        if (hw_we) begin
            nxt.dyn_addr  = hw_addr;
            nxt.dyn_valid = hw_valid;
        end
        return nxt;
    endfunction

    assign wr_req  = cpu_req_i & cpu_req_is_wr_i;
    assign rd_req  = cpu_req_i & ~cpu_req_is_wr_i;
    assign wr_word = cpu_wr_data_i;

    // Address decode
    assign hit_dev    = (cpu_addr_i == `ADDR_DEVICE_ADDR);
    assign hit_virt   = (cpu_addr_i == `ADDR_VIRT_DEVICE_ADDR);
    assign hit_rstact = (cpu_addr_i == `ADDR_RSTACT_PARAMS);
    assign hit_ctrl   = (cpu_addr_i == `ADDR_CONTROL);
    assign hit_any    = hit_dev | hit_virt | hit_rstact | hit_ctrl;

    assign dev_addr_d = merge_addr(dev_addr_q, wr_req & hit_dev, wr_word.addr,
                                   upd_i.dev_we, upd_i.dyn_addr_next, upd_i.dyn_valid_next);
    assign virt_addr_d = merge_addr(virt_addr_q, wr_req & hit_virt, wr_word.addr,
                                    upd_i.virt_we, upd_i.dyn_addr_next, upd_i.dyn_valid_next);
    assign xact_en_d = (wr_req & hit_ctrl) ? wr_word.raw[`CTRL_XACT_EN_BIT] : xact_en_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin : regs
        if (!arst_n_i) begin
            dev_addr_q  <= '0;
            virt_addr_q <= '0;
            rstact_q    <= '0;
            xact_en_q   <= 1'b0;
        end else begin
            dev_addr_q  <= dev_addr_d;
            virt_addr_q <= virt_addr_d;
            xact_en_q   <= xact_en_d;
            if (upd_i.rstact_we) begin
                rstact_q <= upd_i.rstact_next; // Only hardware writes it
            end
        end
    end

    always_comb begin : rd_mux
        rd_word.raw = '0;
        if (hit_dev) begin
            rd_word.addr = dev_addr_q;
        end else if (hit_virt) begin
            rd_word.addr = virt_addr_q;
        end else if (hit_rstact) begin
            rd_word.raw[`RSTACT_W-1:0] = rstact_q;
        end else if (hit_ctrl) begin
            rd_word.raw[`CTRL_XACT_EN_BIT] = xact_en_q;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin : acks
        if (!arst_n_i) begin
            cpu_rd_ack_o <= 1'b0;
            cpu_rd_err_o <= 1'b0;
            cpu_wr_ack_o <= 1'b0;
            cpu_wr_err_o <= 1'b0;
        end else begin
            cpu_rd_ack_o <= rd_req;
            cpu_rd_err_o <= rd_req & ~hit_any;
            cpu_wr_ack_o <= wr_req;
            cpu_wr_err_o <= wr_req & ~hit_any;
        end
    end

    always_ff @(posedge clk_i) begin : rd_data
        if (rd_req) begin
            cpu_rd_data_o <= rd_word.raw;
        end
    end

    assign dev_addr_o   = dev_addr_q;
    assign virt_addr_o  = virt_addr_q;
    assign xact_en_o    = xact_en_q;
    assign rst_action_o = rstact_q;

endmodule : stby_csr_regs

`default_nettype wire

/* src/target_addr_match.sv */
`timescale 1ns/1ns
`default_nettype none

`include "i3c_stby_consts.svh"

module target_addr_match
    import i3c_stby_pkg::*;
(
    input  wire logic                   clk_i,
    input  wire logic                   arst_n_i,
    input  wire logic [`I3C_ADDR_W-1:0] bus_addr_i,
    input  wire logic                   bus_addr_valid_i,
    input  wire dev_addr_t              dev_addr_i,
    input  wire dev_addr_t              virt_addr_i,
    input  wire logic                   xact_en_i,
    output logic                        addr_match_o,
    output logic                        virt_match_o
);

    logic dev_dyn_hit;
    logic dev_static_hit;
    logic virt_dyn_hit;
    logic sample; // Bus address present and target enabled

    assign dev_dyn_hit    = dev_addr_i.dyn_valid && (dev_addr_i.dyn_addr == bus_addr_i);
    assign dev_static_hit = dev_addr_i.static_valid && (dev_addr_i.static_addr == bus_addr_i);
    assign virt_dyn_hit   = virt_addr_i.dyn_valid && (virt_addr_i.dyn_addr == bus_addr_i);
    assign sample         = bus_addr_valid_i & xact_en_i;

    always_ff @(posedge clk_i or negedge arst_n_i) begin : match_q
        if (!arst_n_i) begin
            addr_match_o <= 1'b0;
            virt_match_o <= 1'b0;
        end else begin
            addr_match_o <= sample & (dev_dyn_hit | dev_static_hit);
            virt_match_o <= sample & virt_dyn_hit;
        end
    end

endmodule : target_addr_match

`default_nettype wire

/* src/i3c_stby_csr_top.sv */
`timescale 1ns/1ns
`default_nettype none

`include "i3c_stby_consts.svh"

module i3c_stby_csr_top
    import i3c_stby_pkg::*;
(
    input  wire logic                   clk_i,
    input  wire logic                   arst_n_i,

    // CPU port
    input  wire logic                   cpu_req_i,
    input  wire logic                   cpu_req_is_wr_i,
    input  wire logic [`CSR_ADDR_W-1:0] cpu_addr_i,
    input  wire logic [`CSR_DATA_W-1:0] cpu_wr_data_i,
    output logic                        cpu_rd_ack_o,
    output logic                        cpu_rd_err_o,
    output logic [`CSR_DATA_W-1:0]      cpu_rd_data_o,
    output logic                        cpu_wr_ack_o,
    output logic                        cpu_wr_err_o,

    // CCC engine
    input  wire logic [`I3C_ADDR_W-1:0] set_dasa_i,
    input  wire logic                   set_dasa_valid_i,
    input  wire logic                   set_dasa_virtual_i,
    input  wire logic                   rstdaa_i,
    input  wire logic [`I3C_ADDR_W-1:0] newda_i,
    input  wire logic                   set_newda_i,
    input  wire logic                   set_newda_virtual_i,
    input  wire logic [`RSTACT_W-1:0]   rst_action_i,
    input  wire logic                   rst_action_valid_i,

    // Bus side
    input  wire logic [`I3C_ADDR_W-1:0] bus_addr_i,
    input  wire logic                   bus_addr_valid_i,
    output logic                        addr_match_o,
    output logic                        virt_match_o,
    output logic [`RSTACT_W-1:0]        rst_action_o
);

    ccc_addr_if ccc_upd ();

    dev_addr_t dev_addr;
    dev_addr_t virt_addr;
    logic      xact_en;

    ccc_addr_update u_ccc_addr_update (
        .set_dasa_i         (set_dasa_i),
        .set_dasa_valid_i   (set_dasa_valid_i),
        .set_dasa_virtual_i (set_dasa_virtual_i),
        .rstdaa_i           (rstdaa_i),
        .newda_i            (newda_i),
        .set_newda_i        (set_newda_i),
        .set_newda_virtual_i(set_newda_virtual_i),
        .rst_action_i       (rst_action_i),
        .rst_action_valid_i (rst_action_valid_i),
        .upd_o              (ccc_upd.src)
    );

    stby_csr_regs u_stby_csr_regs (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .cpu_req_i      (cpu_req_i),
        .cpu_req_is_wr_i(cpu_req_is_wr_i),
        .cpu_addr_i     (cpu_addr_i),
        .cpu_wr_data_i  (cpu_wr_data_i),
        .cpu_rd_ack_o   (cpu_rd_ack_o),
        .cpu_rd_err_o   (cpu_rd_err_o),
        .cpu_rd_data_o  (cpu_rd_data_o),
        .cpu_wr_ack_o   (cpu_wr_ack_o),
        .cpu_wr_err_o   (cpu_wr_err_o),
        .upd_i          (ccc_upd.dst),
        .dev_addr_o     (dev_addr),
        .virt_addr_o    (virt_addr),
        .xact_en_o      (xact_en),
        .rst_action_o   (rst_action_o)
    );

    target_addr_match u_target_addr_match (
        .clk_i           (clk_i),
        .arst_n_i        (arst_n_i),
        .bus_addr_i      (bus_addr_i),
        .bus_addr_valid_i(bus_addr_valid_i),
        .dev_addr_i      (dev_addr),
        .virt_addr_i     (virt_addr),
        .xact_en_i       (xact_en),
        .addr_match_o    (addr_match_o),
        .virt_match_o    (virt_match_o)
    );

endmodule : i3c_stby_csr_top

`default_nettype wire

/* bench/i3c_stby_assertions.sv */
`timescale 1ns/1ns
`default_nettype none

module i3c_stby_assertions (
    input wire logic clk_i,
    input wire logic arst_n_i,
    input wire logic req_i,
    input wire logic rd_ack_i,
    input wire logic rd_err_i,
    input wire logic wr_ack_i,
    input wire logic wr_err_i
);

    int fail_count = 0; // Failed assertions so far

    // Every ack answers a request from the cycle before
    ack_after_req: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (rd_ack_i || wr_ack_i) |-> $past(req_i))
        else begin
            fail_count++;
            $error("CPU ack without a request in the previous cycle");
        end

    acks_exclusive: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !(rd_ack_i && wr_ack_i))
        else begin
            fail_count++;
            $error("Read and write ack high together");
        end

    err_with_ack: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (rd_err_i |-> rd_ack_i) and (wr_err_i |-> wr_ack_i))
        else begin
            fail_count++;
            $error("CPU error flag without its ack");
        end

endmodule : i3c_stby_assertions

bind stby_csr_regs i3c_stby_assertions u_stby_assert (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .req_i    (cpu_req_i),
    .rd_ack_i (cpu_rd_ack_o),
    .rd_err_i (cpu_rd_err_o),
    .wr_ack_i (cpu_wr_ack_o),
    .wr_err_i (cpu_wr_err_o)
);

`default_nettype wire

/* bench/tb_i3c_stby_csr.sv */
`timescale 1ns/1ns
`default_nettype none

`include "i3c_stby_consts.svh"

module tb_i3c_stby_csr;

    localparam int          NUM_TXN     = 3000;
    localparam int          ACK_TIMEOUT = 16;
    localparam logic [31:0] ADDR_FIELDS = 32'h807F_807F; // Addresses and valids
    localparam logic [`CSR_ADDR_W-1:0] REG_OFFS [4] = '{`ADDR_DEVICE_ADDR,
        `ADDR_VIRT_DEVICE_ADDR, `ADDR_RSTACT_PARAMS, `ADDR_CONTROL};

    logic                   clk_i;
    logic                   arst_n_i;
    logic                   cpu_req_i;
    logic                   cpu_req_is_wr_i;
    logic [`CSR_ADDR_W-1:0] cpu_addr_i;
    logic [`CSR_DATA_W-1:0] cpu_wr_data_i;
    logic                   cpu_rd_ack_o;
    logic                   cpu_rd_err_o;
    logic [`CSR_DATA_W-1:0] cpu_rd_data_o;
    logic                   cpu_wr_ack_o;
    logic                   cpu_wr_err_o;
    logic [`I3C_ADDR_W-1:0] set_dasa_i;
    logic                   set_dasa_valid_i;
    logic                   set_dasa_virtual_i;
    logic                   rstdaa_i;
    logic [`I3C_ADDR_W-1:0] newda_i;
    logic                   set_newda_i;
    logic                   set_newda_virtual_i;
    logic [`RSTACT_W-1:0]   rst_action_i;
    logic                   rst_action_valid_i;
    logic [`I3C_ADDR_W-1:0] bus_addr_i;
    logic                   bus_addr_valid_i;
    logic                   addr_match_o;
    logic                   virt_match_o;
    logic [`RSTACT_W-1:0]   rst_action_o;

    // Reference model
    logic [31:0]          m_dev;
    logic [31:0]          m_virt;
    logic [`RSTACT_W-1:0] m_rstact;
    logic                 m_xact_en;
    logic [31:0]          lcg_state;

    i3c_stby_csr_top dut0 (.*);

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("=== FAIL ===");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            stop_run($sformatf("** Error @ %0t ns: %s = %h, expected %h",
                               $time, what, got, exp));
        end
    endtask

    // Concurrent assertions bound into the register file
    task automatic check_assertions();
        if (dut0.u_stby_csr_regs.u_stby_assert.fail_count != 0) begin
            stop_run("A concurrent assertion on the CPU port failed");
        end
    endtask

    task automatic drive_idle();
        cpu_req_i           <= 1'b0;
        cpu_req_is_wr_i     <= 1'b0;
        cpu_addr_i          <= '0;
        cpu_wr_data_i       <= '0;
        set_dasa_i          <= '0;
        set_dasa_valid_i    <= 1'b0;
        set_dasa_virtual_i  <= 1'b0;
        rstdaa_i            <= 1'b0;
        newda_i             <= '0;
        set_newda_i         <= 1'b0;
        set_newda_virtual_i <= 1'b0;
        rst_action_i        <= '0;
        rst_action_valid_i  <= 1'b0;
        bus_addr_i          <= '0;
        bus_addr_valid_i    <= 1'b0;
    endtask

    task automatic drive_read(input logic [`CSR_ADDR_W-1:0] addr, input logic [6:0] bus);
        cpu_req_i        <= 1'b1;
        cpu_req_is_wr_i  <= 1'b0;
        cpu_addr_i       <= addr;
        bus_addr_i       <= bus;
        bus_addr_valid_i <= 1'b1;
    endtask

    task automatic drive_random();
        logic [31:0] r [6];
        for (int k = 0; k < 6; k++) begin
            r[k] = lcg_next();
        end
        cpu_req_i       <= 1'b1;
        cpu_req_is_wr_i <= r[0][16];
        case (r[0][19:17])
            3'd0, 3'd1: cpu_addr_i <= `ADDR_DEVICE_ADDR;
            3'd2, 3'd3: cpu_addr_i <= `ADDR_VIRT_DEVICE_ADDR;
            3'd4:       cpu_addr_i <= `ADDR_RSTACT_PARAMS;
            3'd5:       cpu_addr_i <= `ADDR_CONTROL;
            default:    cpu_addr_i <= r[1][27:16]; // Mostly unmapped
        endcase
        cpu_wr_data_i       <= {r[1][31:16], r[2][31:16]};
        set_dasa_i          <= r[0][26:20];
        set_dasa_valid_i    <= (r[3][18:16] == 3'd0);
        rstdaa_i            <= (r[3][21:19] == 3'd0);
        set_dasa_virtual_i  <= r[3][22];
        set_newda_i         <= (r[3][25:23] == 3'd0);
        set_newda_virtual_i <= (r[3][28:26] == 3'd0);
        rst_action_valid_i  <= (r[3][31:29] == 3'd0);
        newda_i             <= r[4][22:16];
        rst_action_i        <= r[5][23:16];
        // Stored addresses often, so matches really happen
        case (r[0][29:27])
            3'd0:    bus_addr_i <= m_dev[22:16];
            3'd1:    bus_addr_i <= m_dev[6:0];
            3'd2:    bus_addr_i <= m_virt[22:16];
            default: bus_addr_i <= r[4][29:23];
        endcase
        bus_addr_valid_i <= (r[0][31:30] != 2'd0);
    endtask

    // CPU write first, CCC update on top of the dynamic fields
    task automatic update_model();
        logic [`I3C_ADDR_W-1:0] hw_addr;
        logic                   hw_valid;
        logic                   hw_dev;
        logic                   hw_virt;
        if (cpu_req_i && cpu_req_is_wr_i) begin
            case (cpu_addr_i)
                `ADDR_DEVICE_ADDR:      m_dev = cpu_wr_data_i & ADDR_FIELDS;
                `ADDR_VIRT_DEVICE_ADDR: m_virt = cpu_wr_data_i & ADDR_FIELDS;
                `ADDR_CONTROL:          m_xact_en = cpu_wr_data_i[`CTRL_XACT_EN_BIT];
                default: ; // Reset action is read-only here
            endcase
        end
        hw_addr  = newda_i;
        hw_valid = 1'b1;
        hw_dev   = set_newda_i;
        hw_virt  = set_newda_virtual_i;
        if (set_dasa_valid_i || rstdaa_i) begin
            hw_dev   = !set_dasa_virtual_i;
            hw_virt  = set_dasa_virtual_i;
            hw_addr  = rstdaa_i ? '0 : set_dasa_i;
            hw_valid = !rstdaa_i;
        end
        if (hw_dev) begin
            m_dev[22:16] = hw_addr;
            m_dev[31]    = hw_valid;
        end
        if (hw_virt) begin
            m_virt[22:16] = hw_addr;
            m_virt[31]    = hw_valid;
        end
        if (rst_action_valid_i) m_rstact = rst_action_i;
    endtask

    // Predict from the state before this request, then wait for its ack
    task automatic finish_txn();
        logic [31:0] exp_rd;
        logic        exp_err;
        logic        exp_am;
        logic        exp_vm;
        logic        was_wr;
        int          lat;
        @(negedge clk_i);
        was_wr  = cpu_req_is_wr_i;
        exp_err = 1'b0;
        case (cpu_addr_i)
            `ADDR_DEVICE_ADDR:      exp_rd = m_dev;
            `ADDR_VIRT_DEVICE_ADDR: exp_rd = m_virt;
            `ADDR_RSTACT_PARAMS:    exp_rd = {24'd0, m_rstact};
            `ADDR_CONTROL:          exp_rd = {31'd0, m_xact_en};
            default: begin
                exp_rd  = '0;
                exp_err = 1'b1;
            end
        endcase
        exp_am = m_xact_en && bus_addr_valid_i &&
                 ((m_dev[31] && m_dev[22:16] == bus_addr_i) ||
                  (m_dev[15] && m_dev[6:0] == bus_addr_i));
        exp_vm = m_xact_en && bus_addr_valid_i &&
                 m_virt[31] && (m_virt[22:16] == bus_addr_i);
        update_model();
        lat = 0;
        do begin
            @(posedge clk_i);
            drive_idle();
            @(negedge clk_i);
            lat++;
            if (lat > ACK_TIMEOUT) stop_run("Timeout: the CPU request was never acknowledged");
        end while (!cpu_rd_ack_o && !cpu_wr_ack_o);
        check("ack latency", lat, 1);
        check("cpu_rd_ack_o", cpu_rd_ack_o, !was_wr);
        check("cpu_wr_ack_o", cpu_wr_ack_o, was_wr);
        check("cpu_rd_err_o", cpu_rd_err_o, !was_wr && exp_err);
        check("cpu_wr_err_o", cpu_wr_err_o, was_wr && exp_err);
        if (!was_wr) check("cpu_rd_data_o", cpu_rd_data_o, exp_rd);
        check("addr_match_o", addr_match_o, exp_am);
        check("virt_match_o", virt_match_o, exp_vm);
        check("rst_action_o", rst_action_o, m_rstact);
        check_assertions();
    endtask

    initial begin
        lcg_state = 32'd92644;
        m_dev     = '0;
        m_virt    = '0;
        m_rstact  = '0;
        m_xact_en = 1'b0;
        arst_n_i  = 1'b0;
        drive_idle();
        repeat (3) @(posedge clk_i);
        arst_n_i <= 1'b1;

        // Reset values, bus traffic must not match yet
        for (int i = 0; i < 4; i++) begin
            @(posedge clk_i);
            drive_read(REG_OFFS[i], 7'(i));
            finish_txn();
        end

        for (int n = 0; n < NUM_TXN; n++) begin
            @(posedge clk_i);
            drive_random();
            finish_txn();
        end

        for (int i = 0; i < 4; i++) begin
            @(posedge clk_i);
            drive_read(REG_OFFS[i], m_dev[22:16]);
            finish_txn();
        end

        $display("=== PASS ===");
        $finish;
    end

endmodule : tb_i3c_stby_csr

`default_nettype wire

/* tb.f */
+incdir+src
src/i3c_stby_pkg.sv
src/ccc_addr_if.sv
src/ccc_addr_update.sv
src/stby_csr_regs.sv
src/target_addr_match.sv
src/i3c_stby_csr_top.sv
bench/i3c_stby_assertions.sv
bench/tb_i3c_stby_csr.sv

/* Bender.yml */
package:
  name: i3c_stby_csr

sources:
  - include_dirs:
      - src
    files:
      - src/i3c_stby_pkg.sv
      - src/ccc_addr_if.sv
      - src/ccc_addr_update.sv
      - src/stby_csr_regs.sv
      - src/target_addr_match.sv
      - src/i3c_stby_csr_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - bench/i3c_stby_assertions.sv
      - bench/tb_i3c_stby_csr.sv
